// ==== verilog/bch_macros.svh ====
`ifndef BCH_MACROS_SVH
`define BCH_MACROS_SVH

// BCH(15,7) over GF(2^4), corrects up to two bit errors
`define BCH_M 4 // field width
`define BCH_N 15 // codeword length
`define BCH_K 7 // message length
`define BCH_T 2 // correctable errors

// x^4 + x + 1
`define BCH_PRIM_POLY 5'h13

`endif

// ==== verilog/bch_pkg.sv ====
`include "bch_macros.svh"

package bch_pkg;

	typedef logic [`BCH_M-1:0] gf_elem_t; // one field element
	typedef logic [2*`BCH_M-1:0] syndrome_t; // {S1, S3}
	typedef logic [$clog2(`BCH_N)-1:0] bit_pos_t; // 14 down to 0
	typedef logic [$clog2(`BCH_T+1)-1:0] root_cnt_t;

	typedef enum logic
	{
		CHIEN_IDLE,
		CHIEN_RUN
	} chien_state_t;

	// powers of alpha used as fixed multipliers
	localparam gf_elem_t GF_ONE = 4'h1;
	localparam gf_elem_t GF_ALPHA = 4'h2;
	localparam gf_elem_t GF_ALPHA2 = 4'h4;
	localparam gf_elem_t GF_ALPHA3 = 4'h8;

	// shift-and-add product, reduced by the primitive polynomial
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < `BCH_M; i++)
		begin
			if (b[i])
				acc = acc ^ sh;
			// multiply sh by alpha
			sh = {sh[`BCH_M-2:0], 1'b0} ^ (sh[`BCH_M-1] ? gf_elem_t'(`BCH_PRIM_POLY) : '0);
		end
		return acc;
	endfunction

	// a^-1 = a^14 in GF(16); zero maps to zero
	function automatic gf_elem_t gf_inv(input gf_elem_t a);
		gf_elem_t a2;
		gf_elem_t a4;
		gf_elem_t a8;
		a2 = gf_mul(a, a);
		a4 = gf_mul(a2, a2);
		a8 = gf_mul(a4, a4);
		return gf_mul(gf_mul(a8, a4), a2);
	endfunction

endpackage

// ==== verilog/bch_stream_if.sv ====
`timescale 1ns/1ps

// one bit per cycle with frame markers
interface bch_stream_if;

	logic data;
	logic valid;
	logic sof; // only meaningful with valid
	logic eof;

	modport source
	(
		output data,
		output valid,
		output sof,
		output eof
	);

	modport sink
	(
		input data,
		input valid,
		input sof,
		input eof
	);

endinterface

// ==== verilog/bch_key_solver.sv ====
`timescale 1ns/1ps
`include "bch_macros.svh"

module bch_key_solver
	import bch_pkg::*;
(
	input logic I_clk,
	input logic reset,
	input logic in_data,
	input logic in_valid,
	input logic in_sof,
	input logic in_eof,
	output gf_elem_t sigma1,
	output gf_elem_t sigma2,
	output logic [1:0] degree,
	output logic loc_valid
);

	syndrome_t syn; // running {S1, S3}
	gf_elem_t s1_base;
	gf_elem_t s3_base;
	gf_elem_t s1_next;
	gf_elem_t s3_next;
	gf_elem_t s1_cube;
	gf_elem_t s3_diff;
	gf_elem_t sigma2_next;
	logic [1:0] degree_next;

	always_comb
	begin
		// sof restarts both accumulators
		s1_base = in_sof ? '0 : syn[2*`BCH_M-1:`BCH_M];
		s3_base = in_sof ? '0 : syn[`BCH_M-1:0];

		// Horner step, highest coefficient arrives first
		s1_next = gf_mul(s1_base, GF_ALPHA) ^ gf_elem_t'(in_data);
		s3_next = gf_mul(s3_base, GF_ALPHA3) ^ gf_elem_t'(in_data);

		s1_cube = gf_mul(s1_next, gf_mul(s1_next, s1_next));
		s3_diff = s3_next ^ s1_cube; // zero for a single error
		sigma2_next = gf_mul(s3_diff, gf_inv(s1_next));

		if (s1_next == '0)
			degree_next = (s3_next == '0) ? 2'd0 : 2'd3; // 3 flags a bad frame
		else if (s3_diff == '0)
			degree_next = 2'd1;
		else
			degree_next = 2'd2;
	end

	always_ff @(posedge I_clk)
	begin
		if (reset)
			loc_valid <= 1'b0;
		else
			loc_valid <= in_valid & in_eof; // pulse one cycle after eof
	end

	always_ff @(posedge I_clk)
	begin
		if (in_valid)
			syn <= {s1_next, s3_next};
		// locator of the finished frame
		if (in_valid && in_eof)
		begin
			sigma1 <= s1_next;
			sigma2 <= sigma2_next;
			degree <= degree_next;
		end
	end

endmodule

// ==== verilog/bch_chien_search.sv ====
`timescale 1ns/1ps
`include "bch_macros.svh"

module bch_chien_search
	import bch_pkg::*;
(
	input logic I_clk,
	input logic reset,
	input gf_elem_t sigma1,
	input gf_elem_t sigma2,
	input logic [1:0] degree,
	input logic loc_valid,
	bch_stream_if.source err,
	output root_cnt_t root_cnt,
	output logic [1:0] degree_out
);

	chien_state_t state;
	bit_pos_t pos; // position being tested
	gf_elem_t term1; // sigma1 * alpha^(15-pos)
	gf_elem_t term2; // sigma2 * alpha^(2*(15-pos))
	root_cnt_t root_reg; // roots before the current position
	logic flag;
	logic running;

	assign running = (state == CHIEN_RUN);

	// sigma(alpha^-pos) == 0 marks an error at pos
	assign flag = running && ((GF_ONE ^ term1 ^ term2) == '0);

	assign err.data = flag;
	assign err.valid = running;
	assign err.sof = running && (pos == bit_pos_t'(`BCH_N-1));
	assign err.eof = running && (pos == '0);

	// total including this position, complete in the eof cycle
	assign root_cnt = root_reg + root_cnt_t'(flag);

	always_ff @(posedge I_clk)
	begin
		if (reset)
		begin
			state <= CHIEN_IDLE;
			pos <= '0;
		end
		else if (loc_valid)
		begin
			state <= CHIEN_RUN;
			pos <= bit_pos_t'(`BCH_N-1);
		end
		else if (running)
		begin
			if (pos == '0)
				state <= CHIEN_IDLE;
			pos <= pos - 1'b1;
		end
	end

	always_ff @(posedge I_clk)
	begin
		if (loc_valid)
		begin
			// position 14 is tested at alpha^-14 = alpha
			term1 <= gf_mul(sigma1, GF_ALPHA);
			term2 <= gf_mul(sigma2, GF_ALPHA2);
			root_reg <= '0;
			degree_out <= degree; // held for the corrector
		end
		else if (running)
		begin
			term1 <= gf_mul(term1, GF_ALPHA);
			term2 <= gf_mul(term2, GF_ALPHA2);
			root_reg <= root_cnt;
		end
	end

endmodule

// ==== verilog/bch_frame_buffer.sv ====
`timescale 1ns/1ps
`include "bch_macros.svh"

module bch_frame_buffer
	import bch_pkg::*;
(
	input logic I_clk,
	input logic reset,
	input logic in_data,
	input logic in_valid,
	input logic in_sof,
	input logic in_eof,
	bch_stream_if.source rd
);

	logic [`BCH_N-1:0] bank [0:1]; // ping-pong frame store
	logic wr_bank; // bank being filled
	logic rd_bank; // bank being read
	bit_pos_t wr_pos;
	bit_pos_t rd_pos;
	logic eof_d; // first delay stage
	logic rd_active;
	logic rd_data_q;
	logic rd_valid_q;
	logic rd_sof_q;
	logic rd_eof_q;

	assign rd.data = rd_data_q;
	assign rd.valid = rd_valid_q;
	assign rd.sof = rd_sof_q;
	assign rd.eof = rd_eof_q;

	always_ff @(posedge I_clk)
	begin
		if (reset)
		begin
			wr_bank <= 1'b0;
			wr_pos <= '0;
			eof_d <= 1'b0;
			rd_bank <= 1'b0;
			rd_pos <= '0;
			rd_active <= 1'b0;
			rd_valid_q <= 1'b0;
			rd_sof_q <= 1'b0;
			rd_eof_q <= 1'b0;
		end
		else
		begin
			eof_d <= in_valid & in_eof;
			if (in_valid)
			begin
				wr_pos <= in_sof ? bit_pos_t'(`BCH_N-2) : wr_pos - 1'b1;
				if (in_eof)
					wr_bank <= ~wr_bank; // next frame goes to the other bank
			end

			if (eof_d)
			begin
				// second stage, position 14 of the bank just completed
				rd_bank <= ~wr_bank;
				rd_pos <= bit_pos_t'(`BCH_N-2);
				rd_active <= 1'b1;
				rd_valid_q <= 1'b1;
				rd_sof_q <= 1'b1;
				rd_eof_q <= 1'b0;
			end
			else if (rd_active)
			begin
				rd_pos <= rd_pos - 1'b1;
				rd_active <= (rd_pos != '0);
				rd_valid_q <= 1'b1;
				rd_sof_q <= 1'b0;
				rd_eof_q <= (rd_pos == '0);
			end
			else
			begin
				rd_valid_q <= 1'b0;
				rd_sof_q <= 1'b0;
				rd_eof_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge I_clk)
	begin
		if (in_valid)
			bank[wr_bank][in_sof ? bit_pos_t'(`BCH_N-1) : wr_pos] <= in_data;
		rd_data_q <= eof_d ? bank[~wr_bank][`BCH_N-1] : bank[rd_bank][rd_pos];
	end

endmodule

// ==== verilog/bch_corrector.sv ====
`timescale 1ns/1ps

module bch_corrector
	import bch_pkg::*;
(
	input logic I_clk,
	input logic reset,
	bch_stream_if.sink buf_in,
	bch_stream_if.sink err_in,
	input root_cnt_t root_cnt,
	input logic [1:0] degree,
	output logic out_data,
	output logic out_valid,
	output logic out_sof,
	output logic out_eof,
	output logic uncorrectable
);

	logic bad_frame;
	logic err_bit;

	// a degree-2 locator has either two roots or none, so a mismatch
	// means no flag was raised and the bits went through unchanged
	assign bad_frame = (degree == 2'd3) || (root_cnt != degree);

	assign err_bit = err_in.valid & err_in.data;

	always_ff @(posedge I_clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			out_sof <= 1'b0;
			out_eof <= 1'b0;
			uncorrectable <= 1'b0;
		end
		else
		begin
			out_valid <= buf_in.valid;
			out_sof <= buf_in.valid & buf_in.sof;
			out_eof <= buf_in.valid & buf_in.eof;
			// root count is final in the flag stream's last cycle
			uncorrectable <= err_in.valid & err_in.eof & bad_frame;
		end
	end

	always_ff @(posedge I_clk)
	begin
		out_data <= buf_in.data ^ err_bit; // flip flagged bits
	end

endmodule

// ==== verilog/bch_decoder.sv ====
`timescale 1ns/1ps

module bch_decoder
	import bch_pkg::*;
(
	input logic I_clk,
	input logic reset,
	input logic in_data,
	input logic in_valid,
	input logic in_sof,
	input logic in_eof,
	output logic out_data,
	output logic out_valid,
	output logic out_sof,
	output logic out_eof,
	output logic uncorrectable
);

	gf_elem_t sigma1;
	gf_elem_t sigma2;
	logic [1:0] loc_degree; // from the solver
	logic loc_valid;
	root_cnt_t root_cnt;
	logic [1:0] chien_degree; // held during the flag stream

	bch_stream_if buf_if ();
	bch_stream_if err_if ();

	bch_key_solver u_key_solver
	(
		.I_clk (I_clk),
		.reset (reset),
		.in_data (in_data),
		.in_valid (in_valid),
		.in_sof (in_sof),
		.in_eof (in_eof),
		.sigma1 (sigma1),
		.sigma2 (sigma2),
		.degree (loc_degree),
		.loc_valid (loc_valid)
	);

	bch_chien_search u_chien_search
	(
		.I_clk (I_clk),
		.reset (reset),
		.sigma1 (sigma1),
		.sigma2 (sigma2),
		.degree (loc_degree),
		.loc_valid (loc_valid),
		.err (err_if.source),
		.root_cnt (root_cnt),
		.degree_out (chien_degree)
	);

	// received bits wait here while the locator is found
	bch_frame_buffer u_frame_buffer
	(
		.I_clk (I_clk),
		.reset (reset),
		.in_data (in_data),
		.in_valid (in_valid),
		.in_sof (in_sof),
		.in_eof (in_eof),
		.rd (buf_if.source)
	);

	bch_corrector u_corrector
	(
		.I_clk (I_clk),
		.reset (reset),
		.buf_in (buf_if.sink),
		.err_in (err_if.sink),
		.root_cnt (root_cnt),
		.degree (chien_degree),
		.out_data (out_data),
		.out_valid (out_valid),
		.out_sof (out_sof),
		.out_eof (out_eof),
		.uncorrectable (uncorrectable)
	);

endmodule

// ==== test/bch_decoder_properties.sv ====
`timescale 1ns/1ps

module bch_decoder_properties
(
	input logic I_clk,
	input logic reset,
	input logic in_valid,
	input logic in_sof,
	input logic in_eof,
	input logic out_valid,
	input logic out_sof,
	input logic out_eof,
	input logic uncorrectable
);

	int fail_count = 0; // read by the testbench summary
	logic frame_seen; // set by the first input sof

	always_ff @(posedge I_clk)
	begin
		if (reset)
			frame_seen <= 1'b0;
		else if (in_valid && in_sof)
			frame_seen <= 1'b1;
	end

	// fixed latency of 3 cycles, in both directions
	a_eof_to_sof: assert property (@(posedge I_clk) disable iff (reset)
		in_valid && in_eof |-> ##3 out_sof)
	else
	begin
		fail_count++;
		$error("out_sof did not follow in_eof after 3 cycles");
	end

	a_sof_from_eof: assert property (@(posedge I_clk) disable iff (reset)
		out_sof |-> $past(in_valid && in_eof, 3))
	else
	begin
		fail_count++;
		$error("out_sof without an in_eof 3 cycles earlier");
	end

	// 15 contiguous valid cycles, the last one carries eof
	a_frame_length: assert property (@(posedge I_clk) disable iff (reset)
		out_sof |-> (out_valid && !out_eof)[*14] ##1 (out_valid && out_eof))
	else
	begin
		fail_count++;
		$error("output frame is not 15 contiguous valid cycles ending in out_eof");
	end

	a_quiet_before_first_frame: assert property (@(posedge I_clk) disable iff (reset)
		!frame_seen |-> !out_valid && !out_sof && !out_eof && !uncorrectable)
	else
	begin
		fail_count++;
		$error("output active before the first input frame");
	end

	a_unc_at_eof: assert property (@(posedge I_clk) disable iff (reset)
		uncorrectable |-> out_valid && out_eof)
	else
	begin
		fail_count++;
		$error("uncorrectable raised outside the out_eof cycle");
	end

endmodule

bind bch_decoder bch_decoder_properties props
(
	.I_clk (I_clk),
	.reset (reset),
	.in_valid (in_valid),
	.in_sof (in_sof),
	.in_eof (in_eof),
	.out_valid (out_valid),
	.out_sof (out_sof),
	.out_eof (out_eof),
	.uncorrectable (uncorrectable)
);

// ==== test/bch_decoder_tb.sv ====
`timescale 1ns/1ps
`include "bch_macros.svh"

module bch_decoder_tb;

	localparam int NUM_FRAMES = 40;
	localparam logic [8:0] GEN_POLY = 9'h1d1; // x^8 + x^7 + x^6 + x^4 + 1

	logic I_clk = 1'b0;
	logic reset;
	logic in_data;
	logic in_valid;
	logic in_sof;
	logic in_eof;
	logic out_data;
	logic out_valid;
	logic out_sof;
	logic out_eof;
	logic uncorrectable;

	integer seed = 32'h35ef_49f3;
	int check_errors = 0;
	int frames_done = 0;
	logic [`BCH_N-1:0] exp_q[$]; // codewords as encoded
	logic [`BCH_N-1:0] rx_q[$]; // words as sent, errors included
	int nerr_q[$];
	logic [`BCH_N-1:0] out_word;

	always #20 I_clk = ~I_clk;

	bch_decoder dut (.*);

	// remainder of a word divided by the generator, zero for a codeword
	function automatic logic [7:0] gen_remainder(input logic [`BCH_N-1:0] word);
		logic [`BCH_N-1:0] r;
		r = word;
		for (int i = `BCH_N - 1; i >= 8; i--)
		begin
			if (r[i])
				r = r ^ (`BCH_N'(GEN_POLY) << (i - 8));
		end
		return r[7:0];
	endfunction

	task automatic drive(input logic valid, input logic data, input logic sof, input logic eof);
		@(posedge I_clk);
		#1;
		in_valid = valid;
		in_data = data;
		in_sof = sof;
		in_eof = eof;
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles) drive(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	// bit 14 goes first, up to four idle gaps inside the frame
	task automatic send_frame(input logic [`BCH_N-1:0] word, input bit gaps);
		int gaps_left;
		gaps_left = gaps ? 4 : 0;
		for (int i = `BCH_N - 1; i >= 0; i--)
		begin
			if (gaps_left > 0 && ($random(seed) & 3) == 0)
			begin
				gaps_left--;
				drive(1'b0, 1'b0, 1'b0, 1'b0);
			end
			drive(1'b1, word[i], i == `BCH_N - 1, i == 0);
		end
	endtask

	// encode a random message, add errors, queue the expectation and send
	task automatic run_frame(input int nerr, input logic [`BCH_N-1:0] fixed_mask,
		input bit gaps, input int idle_cycles);
		logic [`BCH_N-1:0] cw;
		logic [`BCH_N-1:0] mask;
		cw = {7'($random(seed)), 8'h00};
		cw = cw | gen_remainder(cw); // systematic, parity in the low bits
		mask = fixed_mask;
		while ($countones(mask) < nerr)
			mask[$unsigned($random(seed)) % `BCH_N] = 1'b1;
		exp_q.push_back(cw);
		rx_q.push_back(cw ^ mask);
		nerr_q.push_back($countones(mask));
		send_frame(cw ^ mask, gaps);
		drive_idle(idle_cycles);
	endtask

	task automatic check_frame(input logic [`BCH_N-1:0] got, input logic unc);
		logic [`BCH_N-1:0] exp_cw;
		logic [`BCH_N-1:0] rx;
		int nerr;
		frames_done++;
		if (exp_q.size() == 0)
		begin
			check_errors++;
			$display("%0t: output frame arrived with no input frame pending", $time);
		end
		else
		begin
			exp_cw = exp_q.pop_front();
			rx = rx_q.pop_front();
			nerr = nerr_q.pop_front();
			if (nerr <= `BCH_T)
			begin
				assert (got == exp_cw)
				else
				begin
					check_errors++;
					$display("CHECK FAILED at %0t: out_data expected %h, got %h",
						$time, exp_cw, got);
				end
				assert (unc == 1'b0)
				else
				begin
					check_errors++;
					$display("CHECK FAILED at %0t: uncorrectable expected 0, got %b", $time, unc);
				end
			end
			else
			begin
				// too many errors, flagged or decoded to a nearby codeword
				assert (unc || (gen_remainder(got) == '0 && $countones(got ^ rx) <= `BCH_T))
				else
				begin
					check_errors++;
					$display("%0t: word %h with %0d errors came out as %h, not flagged and %s",
						$time, rx, nerr, got, "not a codeword near the received word");
				end
			end
		end
	endtask

	always @(negedge I_clk)
	begin
		if (!reset && out_valid)
		begin
			out_word = {out_word[`BCH_N-2:0], out_data};
			if (out_eof)
				check_frame(out_word, uncorrectable);
		end
	end

	task automatic print_counts();
		$display("frames checked: %0d of %0d, check errors: %0d, assertion errors: %0d",
			frames_done, NUM_FRAMES, check_errors, dut.props.fail_count);
	endtask

	initial
	begin
		reset = 1'b1;
		in_data = 1'b0;
		in_valid = 1'b0;
		in_sof = 1'b0;
		in_eof = 1'b0;
		repeat (10) @(posedge I_clk);
		#1;
		reset = 1'b0;
		drive_idle(5); // outputs must stay quiet here
		repeat (4) run_frame(0, '0, 1'b0, 2);
		run_frame(1, 15'h4000, 1'b0, 2); // first bit sent
		run_frame(1, 15'h0001, 1'b0, 2); // last bit sent
		repeat (6) run_frame(1, '0, 1'b0, 2);
		repeat (8) run_frame(2, '0, 1'b0, 0); // back to back
		repeat (6) run_frame(3, '0, 1'b0, 1);
		repeat (8) run_frame($unsigned($random(seed)) % 3, '0, 1'b1, 0);
		repeat (6) run_frame($unsigned($random(seed)) % 3, '0, 1'b0, 0);
		drive_idle(2);
		wait (frames_done == NUM_FRAMES);
		repeat (5) @(posedge I_clk);
		print_counts();
		if (check_errors == 0 && dut.props.fail_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// each frame needs at most 20 cycles, plus room for reset and latency
	initial
	begin
		repeat (NUM_FRAMES * 20 + 100) @(posedge I_clk);
		$display("timeout: %0d of %0d frames did not come out",
			NUM_FRAMES - frames_done, NUM_FRAMES);
		print_counts();
		$display("tests failed");
		$finish;
	end

endmodule

// ==== bch_decoder.f ====
+incdir+verilog
verilog/bch_pkg.sv
verilog/bch_stream_if.sv
verilog/bch_key_solver.sv
verilog/bch_chien_search.sv
verilog/bch_frame_buffer.sv
verilog/bch_corrector.sv
verilog/bch_decoder.sv
test/bch_decoder_properties.sv
test/bch_decoder_tb.sv

// ==== Bender.yml ====
package:
  name: bch_decoder

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/bch_pkg.sv
      - verilog/bch_stream_if.sv
      - verilog/bch_key_solver.sv
      - verilog/bch_chien_search.sv
      - verilog/bch_frame_buffer.sv
      - verilog/bch_corrector.sv
      - verilog/bch_decoder.sv
  - target: test
    files:
      - test/bch_decoder_properties.sv
      - test/bch_decoder_tb.sv
